//--- src/lidar_pkg.sv
package lidar_pkg;

	// Echo sample layout
	localparam int SAMPLE_W  = 16;
	localparam int ECHO_W    = 4 * SAMPLE_W;	// rise, fall, dist, rssi from the MSB
	localparam int ADDR_W    = 8;				// 255 samples per sector at most
	localparam int ANGLE_W   = 16;
	localparam int STEP_FRAC = 8;				// Fraction bits of the index step

	// Resolution count is 9 bits, table byte doubled in 0.05 deg mode
	localparam int RESO_W    = ADDR_W + 1;

	typedef enum logic [3:0] {
		RESO_0P1  = 4'd0,
		RESO_0P05 = 4'd1,
		RESO_0P2  = 4'd2,
		RESO_0P33 = 4'd3
	} reso_mode_t;

	// Points per sector with the opto switch off, by mode
	localparam logic [RESO_W-1:0] RESO_TAB [4] = '{
		RESO_W'(90),
		RESO_W'(180),
		RESO_W'(45),
		RESO_W'(27)
	};

	// Code angle count of a full turn, by mode
	localparam logic [ANGLE_W-1:0] CIRCLE_TAB [4] = '{
		ANGLE_W'(3600),
		ANGLE_W'(7200),
		ANGLE_W'(1800),
		ANGLE_W'(1080)
	};

endpackage

//--- src/echo_ram.sv
`timescale 1ns/1ps

module echo_ram import lidar_pkg::*; (
	input  logic              i_clk_50m,
	input  logic              i_wr_en,
	input  logic [ADDR_W-1:0] i_wr_addr,
	input  logic [ECHO_W-1:0] i_wr_data,
	input  logic [ADDR_W-1:0] i_rd_addr,
	output logic [ECHO_W-1:0] o_rd_data
);

	logic [ECHO_W-1:0] mem [2**ADDR_W];

	always_ff @(posedge i_clk_50m) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr];	// Registered read port
	end

endmodule

//--- src/echo_capture.sv
`timescale 1ns/1ps

module echo_capture import lidar_pkg::*; (
	input  logic                i_clk_50m,
	input  logic                i_rst_n,
	input  logic                i_opto_fall,
	input  logic                i_zero_sign,
	input  logic                i_dist_sig,
	input  logic [SAMPLE_W-1:0] i_rise_data,
	input  logic [SAMPLE_W-1:0] i_fall_data,
	input  logic [SAMPLE_W-1:0] i_dist_data,
	input  logic [SAMPLE_W-1:0] i_rssi_data,
	input  logic [ADDR_W-1:0]   i_rd_addr,
	output logic [ECHO_W-1:0]   o_echo_rddata,
	output logic [ADDR_W-1:0]   o_point_num
);

	logic              w_bnd;
	logic              w_room;
	logic              r_bank;		// Bank being read while the other fills
	logic              r_rd_sel;	// Bank of the read now returning
	logic              r_wr_en;
	logic [ADDR_W-1:0] r_wr_cnt;
	logic [ADDR_W-1:0] r_wr_addr;
	logic [ECHO_W-1:0] r_wr_data;
	logic [ADDR_W-1:0] r_point_num;
	logic [1:0]        w_we;
	logic [ECHO_W-1:0] w_rd_data [2];

	assign w_bnd  = i_opto_fall | i_zero_sign;
	assign w_room = (r_wr_cnt != '1);	// Count saturates at 255

	// A sample on the boundary cycle itself is dropped
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_wr_en     <= 1'b0;
			r_wr_cnt    <= '0;
			r_point_num <= '0;
			r_bank      <= 1'b0;
			r_rd_sel    <= 1'b0;
		end else begin
			r_wr_en  <= i_dist_sig & ~w_bnd & w_room;
			r_rd_sel <= r_bank;
			if (w_bnd) begin
				r_point_num <= r_wr_cnt;
				r_wr_cnt    <= '0;
				r_bank      <= ~r_bank;
			end else if (i_dist_sig && w_room) begin
				r_wr_cnt <= r_wr_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (i_dist_sig) begin
			r_wr_data <= {i_rise_data, i_fall_data, i_dist_data, i_rssi_data};
			r_wr_addr <= r_wr_cnt;
		end
	end

	assign w_we[0] = r_wr_en & r_bank;
	assign w_we[1] = r_wr_en & ~r_bank;

	for (genvar b = 0; b < 2; b++) begin : g_bank
		echo_ram u_ram (
			.i_clk_50m (i_clk_50m),
			.i_wr_en   (w_we[b]),
			.i_wr_addr (r_wr_addr),
			.i_wr_data (r_wr_data),
			.i_rd_addr (i_rd_addr),
			.o_rd_data (w_rd_data[b])
		);
	end

	assign o_echo_rddata = w_rd_data[r_rd_sel];
	assign o_point_num   = r_point_num;

	// The bank returning read data is never written
	a_no_wr_rd_bank: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		!w_we[r_rd_sel]);

endmodule

//--- src/sector_angle.sv
`timescale 1ns/1ps

module sector_angle import lidar_pkg::*; (
	input  logic               i_clk_50m,
	input  logic               i_rst_n,
	input  logic               i_opto_fall,
	input  logic               i_zero_sign,
	input  logic [3:0]         i_reso_mode,
	input  logic               i_opto_switch,
	input  logic [7:0]         i_opto_rddata,
	output logic [ADDR_W-1:0]  o_opto_rdaddr,
	output logic [ANGLE_W-1:0] o_sec_angle,
	output logic [RESO_W-1:0]  o_reso_cnt,
	output logic [ANGLE_W-1:0] o_angle_max
);

	reso_mode_t         r_mode;
	logic               r_switch;
	logic [7:0]         r_tab;			// Calibration byte of this sector
	logic [ADDR_W-1:0]  r_rdaddr;
	logic [RESO_W-1:0]  r_reso;
	logic [ANGLE_W-1:0] r_max;
	logic [ANGLE_W-1:0] r_acc;			// Start angle of the sector in progress
	logic [ANGLE_W-1:0] r_sec_angle;

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_mode   <= RESO_0P1;
			r_switch <= 1'b0;
			r_tab    <= '0;
		end else begin
			r_mode   <= reso_mode_t'(i_reso_mode);
			r_switch <= i_opto_switch;
			r_tab    <= i_opto_rddata;
		end
	end

	// Table address is the sector number within the turn
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n)
			r_rdaddr <= '0;
		else if (i_zero_sign)
			r_rdaddr <= '0;
		else if (i_opto_fall)
			r_rdaddr <= r_rdaddr + 1'b1;
	end

	// Unknown mode codes leave R and the circle count as they were
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_reso <= RESO_TAB[0];
			r_max  <= CIRCLE_TAB[0];
		end else begin
			case (r_mode)
				RESO_0P1: begin
					r_reso <= r_switch ? {1'b0, r_tab} : RESO_TAB[0];
					r_max  <= CIRCLE_TAB[0];
				end
				RESO_0P05: begin
					r_reso <= r_switch ? {r_tab, 1'b0} : RESO_TAB[1];	// Twice the byte
					r_max  <= CIRCLE_TAB[1];
				end
				RESO_0P2, RESO_0P33: begin
					r_reso <= RESO_TAB[r_mode[1:0]];
					r_max  <= CIRCLE_TAB[r_mode[1:0]];
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_acc       <= '0;
			r_sec_angle <= '0;
		end else if (i_zero_sign) begin
			r_sec_angle <= r_acc;
			r_acc       <= '0;
		end else if (i_opto_fall) begin
			r_sec_angle <= r_acc;
			r_acc       <= r_acc + ANGLE_W'(r_reso);
		end
	end

	assign o_opto_rdaddr = r_rdaddr;
	assign o_sec_angle   = r_sec_angle;
	assign o_reso_cnt    = r_reso;
	assign o_angle_max   = r_max;

	// Start angle is bounded by one turn plus a full table of sectors
	a_sec_angle_range: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		18'(r_sec_angle) < 18'(r_max) + 18'(r_reso) * 18'd255);

endmodule

//--- src/point_divider.sv
`timescale 1ns/1ps

module point_divider import lidar_pkg::*; (
	input  logic                  i_clk_50m,
	input  logic                  i_rst_n,
	input  logic                  i_div_start,
	input  logic [2*ADDR_W-1:0]   i_dividend,
	input  logic [ADDR_W-1:0]     i_divisor,
	output logic [2*ADDR_W-1:0]   o_quotient,
	output logic                  o_div_done
);

	localparam int DVD_W = 2 * ADDR_W;

	logic [4:0]        r_cnt;		// Quotient bits still to produce
	logic              r_done;
	logic [DVD_W-1:0]  r_dvd;		// Dividend shifts out, quotient shifts in
	logic [ADDR_W-1:0] r_rem;
	logic [ADDR_W-1:0] r_dsr;
	logic [ADDR_W:0]   w_trial;
	logic [ADDR_W:0]   w_diff;
	logic              w_ge;

	assign w_trial = {r_rem, r_dvd[DVD_W-1]};
	assign w_diff  = w_trial - {1'b0, r_dsr};
	assign w_ge    = (w_trial >= {1'b0, r_dsr});

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_cnt  <= '0;
			r_done <= 1'b0;
		end else begin
			r_done <= 1'b0;
			if (i_div_start) begin
				r_cnt <= 5'(DVD_W);
			end else if (r_cnt != '0) begin
				r_cnt <= r_cnt - 1'b1;
				if (r_cnt == 5'd1)
					r_done <= 1'b1;		// Last bit lands with the done pulse
			end
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (i_div_start) begin
			r_dvd <= i_dividend;
			r_rem <= '0;
			r_dsr <= i_divisor;
		end else if (r_cnt != '0) begin
			r_rem <= w_ge ? w_diff[ADDR_W-1:0] : w_trial[ADDR_W-1:0];
			r_dvd <= {r_dvd[DVD_W-2:0], w_ge};
		end
	end

	assign o_quotient = r_dvd;
	assign o_div_done = r_done;

	a_no_start_busy: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		i_div_start |-> (r_cnt == '0));

endmodule

//--- src/point_resampler.sv
`timescale 1ns/1ps

module point_resampler import lidar_pkg::*; #(
	parameter int CREDITS = 4
) (
	input  logic                i_clk_50m,
	input  logic                i_rst_n,
	input  logic                i_opto_fall,
	input  logic                i_zero_sign,
	input  logic [ADDR_W-1:0]   i_point_num,
	input  logic [ANGLE_W-1:0]  i_sec_angle,
	input  logic [RESO_W-1:0]   i_reso_cnt,
	input  logic [ANGLE_W-1:0]  i_angle_max,
	input  logic [ANGLE_W-1:0]  i_angle_zero,
	output logic                o_div_start,
	output logic [2*ADDR_W-1:0] o_dividend,
	output logic [ADDR_W-1:0]   o_divisor,
	input  logic [2*ADDR_W-1:0] i_quotient,
	input  logic                i_div_done,
	output logic [ADDR_W-1:0]   o_rd_addr,
	input  logic [ECHO_W-1:0]   i_echo_rddata,
	output logic                o_pt_valid,
	output logic [ANGLE_W-1:0]  o_pt_angle,
	output logic [ECHO_W-1:0]   o_pt_data,
	input  logic                i_pt_credit,
	output logic                o_sector_done,
	output logic                o_overrun
);

	localparam int CRED_W = $clog2(CREDITS + 1);

	typedef enum logic [2:0] {
		IDLE,
		LAUNCH,
		DIVIDE,
		ADDR,
		EMIT,
		DONE
	} resample_state_t;

	resample_state_t      r_state;
	logic                 r_bnd;			// Boundary seen one cycle late
	logic                 r_q_ok;			// Quotient arrived
	logic                 r_pt_valid;
	logic                 r_sector_done;
	logic                 r_overrun;
	logic [CRED_W-1:0]    r_credit;
	logic [RESO_W-1:0]    r_k;				// Output point number
	logic [RESO_W-1:0]    r_r;
	logic [ADDR_W-1:0]    r_n;
	logic [ANGLE_W-1:0]   r_max;
	logic [ANGLE_W:0]     r_angle;			// Extra bit holds the unwrapped sum
	logic [2*ADDR_W-1:0]  r_idx;			// Sample index in 8.8 fixed point
	logic [ECHO_W-1:0]    r_pt_data;
	logic [ANGLE_W-1:0]   r_pt_angle;
	logic                 w_spend;
	logic                 w_last;
	logic                 w_wrapped;
	logic [ANGLE_W:0]     w_angle_inc;

	assign w_spend     = (r_state == EMIT) && (r_credit != '0);
	assign w_last      = (r_k == r_r - 1'b1);
	assign w_wrapped   = (r_angle < {1'b0, r_max});
	assign w_angle_inc = r_angle + 1'b1;

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state       <= IDLE;
			r_bnd         <= 1'b0;
			r_q_ok        <= 1'b0;
			r_pt_valid    <= 1'b0;
			r_sector_done <= 1'b0;
			r_overrun     <= 1'b0;
			r_credit      <= CRED_W'(CREDITS);
			r_k           <= '0;
		end else begin
			r_bnd         <= i_opto_fall | i_zero_sign;
			r_pt_valid    <= w_spend;
			r_sector_done <= 1'b0;
			r_overrun     <= r_bnd && (r_state != IDLE);	// Sector dropped rather than queued
			r_credit      <= r_credit + CRED_W'(i_pt_credit) - CRED_W'(w_spend);
			case (r_state)
				IDLE: begin
					if (r_bnd) begin
						if (i_point_num == '0 || i_reso_cnt == '0)
							r_sector_done <= 1'b1;	// Nothing to replay
						else
							r_state <= LAUNCH;
					end
				end
				LAUNCH: begin
					r_q_ok  <= 1'b0;
					r_k     <= '0;
					r_state <= DIVIDE;
				end
				DIVIDE: begin
					if (i_div_done)
						r_q_ok <= 1'b1;
					// Start angle keeps wrapping while the divider runs
					if ((r_q_ok || i_div_done) && w_wrapped)
						r_state <= ADDR;
				end
				ADDR:
					r_state <= EMIT;		// RAM read in flight
				EMIT: begin
					if (w_spend) begin
						r_k     <= r_k + 1'b1;
						r_state <= w_last ? DONE : ADDR;
					end
				end
				DONE: begin
					r_sector_done <= 1'b1;
					r_state       <= IDLE;
				end
				default:
					r_state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (r_state == IDLE && r_bnd) begin
			r_n     <= i_point_num;
			r_r     <= i_reso_cnt;
			r_max   <= i_angle_max;
			r_angle <= {1'b0, i_sec_angle} + {1'b0, i_angle_zero};
		end
		if (r_state == LAUNCH)
			r_idx <= '0;
		if ((r_state == LAUNCH || r_state == DIVIDE) && !w_wrapped)
			r_angle <= r_angle - {1'b0, r_max};
		if (w_spend) begin
			r_pt_data  <= i_echo_rddata;
			r_pt_angle <= r_angle[ANGLE_W-1:0];
			r_idx      <= r_idx + i_quotient;
			r_angle    <= (w_angle_inc >= {1'b0, r_max}) ? '0 : w_angle_inc;
		end
	end

	// R above 255 is always even here so both sides of the division are halved
	assign o_div_start = (r_state == LAUNCH);
	assign o_dividend  = r_r[RESO_W-1] ? {1'b0, r_n, {(STEP_FRAC-1){1'b0}}}
	                                   : {r_n, {STEP_FRAC{1'b0}}};
	assign o_divisor   = r_r[RESO_W-1] ? r_r[RESO_W-1:1] : r_r[ADDR_W-1:0];

	assign o_rd_addr     = r_idx[2*ADDR_W-1 -: ADDR_W];	// Integer part of k*Q
	assign o_pt_valid    = r_pt_valid;
	assign o_pt_angle    = r_pt_angle;
	assign o_pt_data     = r_pt_data;
	assign o_sector_done = r_sector_done;
	assign o_overrun     = r_overrun;

	a_credit_max: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		r_credit <= CRED_W'(CREDITS));

	// A point on the output still holds its credit
	a_valid_credit: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		r_pt_valid |-> (r_credit < CRED_W'(CREDITS)));

endmodule

//--- src/lidar_resample_top.sv
`timescale 1ns/1ps

module lidar_resample_top import lidar_pkg::*; #(
	parameter int CREDITS = 4
) (
	input  logic                i_clk_50m,
	input  logic                i_rst_n,
	input  logic                i_opto_fall,
	input  logic                i_zero_sign,
	input  logic [3:0]          i_reso_mode,
	input  logic [ANGLE_W-1:0]  i_angle_zero,
	input  logic                i_opto_switch,
	input  logic [7:0]          i_opto_rddata,
	output logic [ADDR_W-1:0]   o_opto_rdaddr,
	input  logic                i_dist_sig,
	input  logic [SAMPLE_W-1:0] i_rise_data,
	input  logic [SAMPLE_W-1:0] i_fall_data,
	input  logic [SAMPLE_W-1:0] i_dist_data,
	input  logic [SAMPLE_W-1:0] i_rssi_data,
	output logic                o_pt_valid,
	output logic [ANGLE_W-1:0]  o_pt_angle,
	output logic [ECHO_W-1:0]   o_pt_data,
	input  logic                i_pt_credit,
	output logic                o_sector_done,
	output logic                o_overrun
);

	logic [ADDR_W-1:0]   w_rd_addr;
	logic [ECHO_W-1:0]   w_echo_rddata;
	logic [ADDR_W-1:0]   w_point_num;
	logic [ANGLE_W-1:0]  w_sec_angle;
	logic [RESO_W-1:0]   w_reso_cnt;
	logic [ANGLE_W-1:0]  w_angle_max;
	logic                w_div_start;
	logic [2*ADDR_W-1:0] w_dividend;
	logic [ADDR_W-1:0]   w_divisor;
	logic [2*ADDR_W-1:0] w_quotient;
	logic                w_div_done;

	echo_capture u_capture (
		.i_clk_50m     (i_clk_50m),
		.i_rst_n       (i_rst_n),
		.i_opto_fall   (i_opto_fall),
		.i_zero_sign   (i_zero_sign),
		.i_dist_sig    (i_dist_sig),
		.i_rise_data   (i_rise_data),
		.i_fall_data   (i_fall_data),
		.i_dist_data   (i_dist_data),
		.i_rssi_data   (i_rssi_data),
		.i_rd_addr     (w_rd_addr),
		.o_echo_rddata (w_echo_rddata),
		.o_point_num   (w_point_num)
	);

	sector_angle u_angle (
		.i_clk_50m     (i_clk_50m),
		.i_rst_n       (i_rst_n),
		.i_opto_fall   (i_opto_fall),
		.i_zero_sign   (i_zero_sign),
		.i_reso_mode   (i_reso_mode),
		.i_opto_switch (i_opto_switch),
		.i_opto_rddata (i_opto_rddata),
		.o_opto_rdaddr (o_opto_rdaddr),
		.o_sec_angle   (w_sec_angle),
		.o_reso_cnt    (w_reso_cnt),
		.o_angle_max   (w_angle_max)
	);

	point_divider u_divider (
		.i_clk_50m   (i_clk_50m),
		.i_rst_n     (i_rst_n),
		.i_div_start (w_div_start),
		.i_dividend  (w_dividend),
		.i_divisor   (w_divisor),
		.o_quotient  (w_quotient),
		.o_div_done  (w_div_done)
	);

	point_resampler #(
		.CREDITS (CREDITS)
	) u_resampler (
		.i_clk_50m     (i_clk_50m),
		.i_rst_n       (i_rst_n),
		.i_opto_fall   (i_opto_fall),
		.i_zero_sign   (i_zero_sign),
		.i_point_num   (w_point_num),
		.i_sec_angle   (w_sec_angle),
		.i_reso_cnt    (w_reso_cnt),
		.i_angle_max   (w_angle_max),
		.i_angle_zero  (i_angle_zero),
		.o_div_start   (w_div_start),
		.o_dividend    (w_dividend),
		.o_divisor     (w_divisor),
		.i_quotient    (w_quotient),
		.i_div_done    (w_div_done),
		.o_rd_addr     (w_rd_addr),
		.i_echo_rddata (w_echo_rddata),
		.o_pt_valid    (o_pt_valid),
		.o_pt_angle    (o_pt_angle),
		.o_pt_data     (o_pt_data),
		.i_pt_credit   (i_pt_credit),
		.o_sector_done (o_sector_done),
		.o_overrun     (o_overrun)
	);

endmodule

//--- tests/tb_lidar_resample.sv
`timescale 1ns/1ps

module tb_lidar_resample import lidar_pkg::*; ();

	localparam int CREDITS      = 4;
	localparam int NUM_SECT     = 19;
	localparam int R_MAX        = 510;		// Twice the largest table byte
	localparam int WATCHDOG_CYC = NUM_SECT * (255 + R_MAX * 10) + 20000;

	logic                i_clk_50m;
	logic                i_rst_n;
	logic                i_opto_fall;
	logic                i_zero_sign;
	logic [3:0]          i_reso_mode;
	logic [ANGLE_W-1:0]  i_angle_zero;
	logic                i_opto_switch;
	logic [7:0]          i_opto_rddata;
	logic [ADDR_W-1:0]   o_opto_rdaddr;
	logic                i_dist_sig;
	logic [SAMPLE_W-1:0] i_rise_data;
	logic [SAMPLE_W-1:0] i_fall_data;
	logic [SAMPLE_W-1:0] i_dist_data;
	logic [SAMPLE_W-1:0] i_rssi_data;
	logic                o_pt_valid;
	logic [ANGLE_W-1:0]  o_pt_angle;
	logic [ECHO_W-1:0]   o_pt_data;
	logic                i_pt_credit;
	logic                o_sector_done;
	logic                o_overrun;

	// Reference model of captured sectors
	logic [ECHO_W-1:0] smp_store [8192];
	logic [7:0]        cal_tab [256];
	logic [7:0]        tab_addr_q;
	int                smp_ptr, sect_base, smp_cnt;
	int                acc, tab_addr, cur_mode;
	bit                cur_sw;
	int                q_base[$], q_n[$], q_r[$], q_start[$], q_circle[$];
	bit                q_chk[$];		// Cleared when an overrun corrupts the read bank
	int                cur_k, errors, pts_recv, creds_back, credit_pending, credit_wait;
	int                ovr_exp, ovr_seen, sect_done, sect_closed;
	bit                hold_credits;

	lidar_resample_top #(
		.CREDITS (CREDITS)
	) UUT (
		.i_clk_50m     (i_clk_50m),
		.i_rst_n       (i_rst_n),
		.i_opto_fall   (i_opto_fall),
		.i_zero_sign   (i_zero_sign),
		.i_reso_mode   (i_reso_mode),
		.i_angle_zero  (i_angle_zero),
		.i_opto_switch (i_opto_switch),
		.i_opto_rddata (i_opto_rddata),
		.o_opto_rdaddr (o_opto_rdaddr),
		.i_dist_sig    (i_dist_sig),
		.i_rise_data   (i_rise_data),
		.i_fall_data   (i_fall_data),
		.i_dist_data   (i_dist_data),
		.i_rssi_data   (i_rssi_data),
		.o_pt_valid    (o_pt_valid),
		.o_pt_angle    (o_pt_angle),
		.o_pt_data     (o_pt_data),
		.i_pt_credit   (i_pt_credit),
		.o_sector_done (o_sector_done),
		.o_overrun     (o_overrun)
	);

	initial begin
		i_clk_50m = 1'b0;
		forever #10 i_clk_50m = ~i_clk_50m;
	end

	task automatic tick();
		@(posedge i_clk_50m);
		#2;
	endtask

	// Points per sector and full circle from the mode table
	function automatic int exp_reso(int mode, bit sw, int tab);
		case (mode)
			0: return sw ? tab : 90;
			1: return sw ? 2 * tab : 180;
			2: return 45;
			default: return 27;
		endcase
	endfunction

	function automatic int exp_circle(int mode);
		case (mode)
			0: return 3600;
			1: return 7200;
			2: return 1800;
			default: return 1080;
		endcase
	endfunction

	task automatic set_mode(int mode, bit sw, int zero);
		cur_mode      = mode;
		cur_sw        = sw;
		i_reso_mode   = 4'(mode);
		i_opto_switch = sw;
		i_angle_zero  = ANGLE_W'(zero);
	endtask

	task automatic drive_samples(int n);
		logic [ECHO_W-1:0] d;
		for (int i = 0; i < n; i++) begin
			d = {$urandom, $urandom};
			i_dist_sig = 1'b1;
			{i_rise_data, i_fall_data, i_dist_data, i_rssi_data} = d;
			if (smp_cnt < 255) begin	// DUT count saturates here
				smp_store[smp_ptr] = d;
				smp_ptr++;
				smp_cnt++;
			end
			tick();
		end
		i_dist_sig = 1'b0;
	endtask

	task automatic close_sector(bit zero, bit wait_idle);
		int r;
		int circle;
		if (wait_idle)
			while (q_n.size() != 0)
				tick();
		repeat (3) tick();
		r      = exp_reso(cur_mode, cur_sw, cal_tab[tab_addr]);
		circle = exp_circle(cur_mode);
		if (q_n.size() != 0) begin
			ovr_exp++;		// Replay still running so this sector is dropped
			q_chk[0] = 1'b0;
		end else begin
			q_base.push_back(sect_base);
			q_n.push_back(smp_cnt);
			q_r.push_back(r);
			q_start.push_back((acc + int'(i_angle_zero)) % circle);
			q_circle.push_back(circle);
			q_chk.push_back(1'b1);
		end
		sect_closed++;
		sect_base = smp_ptr;
		smp_cnt   = 0;
		acc       = zero ? 0 : (acc + r) & 16'hffff;
		tab_addr  = zero ? 0 : (tab_addr + 1) & 8'hff;
		if (zero)
			i_zero_sign = 1'b1;
		else
			i_opto_fall = 1'b1;
		tick();
		i_zero_sign = 1'b0;
		i_opto_fall = 1'b0;
		repeat (2) tick();		// Descriptor latched before inputs move
		assert (o_opto_rdaddr == ADDR_W'(tab_addr)) else begin
			errors++;
			$display("FAIL %0t o_opto_rdaddr expected %0d actual %0d",
				$time, tab_addr, o_opto_rdaddr);
		end
	endtask

	// Calibration table answering one cycle after the address
	initial begin
		tab_addr_q = '0;
		forever begin
			@(posedge i_clk_50m);
			#2;
			i_opto_rddata = cal_tab[tab_addr_q];
			tab_addr_q    = o_opto_rdaddr;
		end
	end

	initial begin
		i_pt_credit = 1'b0;
		forever begin
			@(posedge i_clk_50m);
			#2;
			if (i_pt_credit) begin
				i_pt_credit = 1'b0;
			end else if (credit_pending > 0 && !hold_credits) begin
				if (credit_wait == 0) begin
					i_pt_credit = 1'b1;
					credit_pending--;
					creds_back++;
					credit_wait = ($urandom % 32 == 0) ? 40 : $urandom_range(6, 0);
				end else begin
					credit_wait--;
				end
			end
		end
	end

	always @(negedge i_clk_50m) begin : check_outputs
		int q;
		int idx;
		int exp_ang;
		int exp_pts;
		if (i_rst_n) begin
			if (o_pt_valid) begin
				pts_recv++;
				credit_pending++;
				if (q_n.size() == 0) begin
					errors++;
					$display("Point output at %0t with no sector waiting for replay", $time);
				end else begin
					q       = (q_n[0] * 256) / q_r[0];
					idx     = (cur_k * q) >> 8;
					exp_ang = (q_start[0] + cur_k) % q_circle[0];
					assert (cur_k < q_r[0]) else begin
						errors++;
						$display("FAIL %0t o_pt_valid count expected %0d actual %0d",
							$time, q_r[0], cur_k + 1);
					end
					assert (o_pt_angle == ANGLE_W'(exp_ang)) else begin
						errors++;
						$display("FAIL %0t o_pt_angle expected %0d actual %0d",
							$time, exp_ang, o_pt_angle);
					end
					if (q_chk[0] && cur_k < q_r[0])
						assert (o_pt_data == smp_store[q_base[0] + idx]) else begin
							errors++;
							$display("FAIL %0t o_pt_data expected %h actual %h",
								$time, smp_store[q_base[0] + idx], o_pt_data);
						end
					cur_k++;
				end
			end
			if (o_sector_done) begin
				sect_done++;
				if (q_n.size() == 0) begin
					errors++;
					$display("Sector done at %0t with no sector waiting for replay", $time);
				end else begin
					exp_pts = (q_n[0] > 0 && q_r[0] > 0) ? q_r[0] : 0;
					assert (cur_k == exp_pts) else begin
						errors++;
						$display("FAIL %0t o_pt_valid points per sector expected %0d actual %0d",
							$time, exp_pts, cur_k);
					end
					void'(q_base.pop_front());
					void'(q_n.pop_front());
					void'(q_r.pop_front());
					void'(q_start.pop_front());
					void'(q_circle.pop_front());
					void'(q_chk.pop_front());
					cur_k = 0;
				end
			end
			if (o_overrun)
				ovr_seen++;
		end
	end

	a_valid_gap: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		o_pt_valid |=> !o_pt_valid) else begin
		errors++;
		$display("Points on two consecutive cycles at %0t", $time);
	end

	a_outstanding: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		(pts_recv - creds_back) <= CREDITS) else begin
		errors++;
		$display("FAIL %0t outstanding points expected at most %0d actual %0d",
			$time, CREDITS, pts_recv - creds_back);
	end

	a_overrun_pulse: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		o_overrun |=> !o_overrun) else begin
		errors++;
		$display("Overrun held longer than one cycle at %0t", $time);
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge i_clk_50m);
		$display("Timeout after %0d cycles, replay did not complete", WATCHDOG_CYC);
		$display("test failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hcda24a9a));
		i_rst_n       = 1'b0;
		i_opto_fall   = 1'b0;
		i_zero_sign   = 1'b0;
		i_dist_sig    = 1'b0;
		i_rise_data   = '0;
		i_fall_data   = '0;
		i_dist_data   = '0;
		i_rssi_data   = '0;
		i_opto_rddata = '0;
		for (int a = 0; a < 256; a++)
			cal_tab[a] = 8'(20 + (a * 73) % 200);
		set_mode(0, 1'b0, 1000);
		repeat (8) @(posedge i_clk_50m);
		#2;
		i_rst_n = 1'b1;

		close_sector(1'b1, 1'b1);		// Empty sector
		drive_samples(200);				// N above R
		close_sector(1'b0, 1'b1);
		drive_samples(40);				// N below R
		close_sector(1'b0, 1'b1);
		drive_samples(70);
		close_sector(1'b1, 1'b1);
		set_mode(1, 1'b0, 7100);
		drive_samples(260);				// Count saturates at 255
		close_sector(1'b0, 1'b1);
		drive_samples(1 + $urandom % 255);
		close_sector(1'b0, 1'b1);
		hold_credits = 1'b1;			// Stall output on a long credit hold
		repeat (100) tick();
		assert ((pts_recv - creds_back) == CREDITS) else begin
			errors++;
			$display("FAIL %0t outstanding points expected %0d actual %0d",
				$time, CREDITS, pts_recv - creds_back);
		end
		hold_credits = 1'b0;
		drive_samples(30);
		close_sector(1'b1, 1'b1);
		set_mode(2, 1'b0, 1790);
		drive_samples(100);
		close_sector(1'b0, 1'b1);
		drive_samples(10);
		close_sector(1'b1, 1'b1);
		set_mode(3, 1'b0, 1000);
		drive_samples(27);
		close_sector(1'b0, 1'b1);
		drive_samples(150);
		close_sector(1'b1, 1'b1);
		set_mode(0, 1'b1, $urandom % 3600);	// Table byte as R
		drive_samples(120);
		close_sector(1'b0, 1'b1);
		drive_samples(60);
		close_sector(1'b1, 1'b1);
		set_mode(1, 1'b1, $urandom % 7200);	// Twice the table byte
		drive_samples(200);
		close_sector(1'b0, 1'b1);
		drive_samples(90);
		close_sector(1'b0, 1'b1);
		drive_samples(250);				// R above 255 here
		close_sector(1'b1, 1'b1);
		set_mode(0, 1'b0, 500);
		drive_samples(150);
		close_sector(1'b0, 1'b1);
		drive_samples(20);
		while (cur_k == 0)
			tick();
		close_sector(1'b0, 1'b0);		// Boundary during replay
		drive_samples(50);
		close_sector(1'b1, 1'b1);

		while (q_n.size() != 0)
			tick();
		repeat (20) tick();
		assert (ovr_seen == ovr_exp) else begin
			errors++;
			$display("FAIL %0t o_overrun pulses expected %0d actual %0d",
				$time, ovr_exp, ovr_seen);
		end
		assert (sect_done == sect_closed - ovr_exp) else begin
			errors++;
			$display("FAIL %0t o_sector_done pulses expected %0d actual %0d",
				$time, sect_closed - ovr_exp, sect_done);
		end
		$display("Run complete: %0d errors, %0d points, %0d sectors done, %0d overruns",
			errors, pts_recv, sect_done, ovr_seen);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- lidar_resample.f
src/lidar_pkg.sv
src/echo_ram.sv
src/echo_capture.sv
src/sector_angle.sv
src/point_divider.sv
src/point_resampler.sv
src/lidar_resample_top.sv
tests/tb_lidar_resample.sv
